//--- list.f
src/pipelineParams.sv
src/resultFormat.sv
src/botInputFifo.sv
src/botPermuter.sv
src/pcoeffAggregator.sv
src/resultsFifo.sv
src/aggregatingPermutePipeline.sv
tests/aggregatingPermutePipelineTb.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f list.f \
    --top-module aggregatingPermutePipelineTb \
    --Mdir obj_dir \
    -o simv

./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "^Regression passed$" sim.log; then
    echo "Simulation PASS"
    exit 0
else
    echo "Simulation FAIL, see sim.log"
    exit 1
fi

//--- src/aggregatingPermutePipeline.sv
`timescale 1ns/10ps
`default_nettype none

module aggregatingPermutePipeline import pipelineParams::*, resultFormat::*; (
    input  logic clk,
    input  logic rst,
    input  logic [1:0] topChannel,

    input  logic [numberOfPermutators*botWidth-1:0] botsIn,
    input  logic [numberOfPermutators*permuteWidth-1:0] validBotsPermutes,
    input  logic [numberOfPermutators-1:0] batchesDone,
    output logic [numberOfPermutators-1:0] slowDownInputs,

    input  logic grabResults,
    output logic resultsAvailable,
    output logic [pcoeffSumWidth-1:0] pcoeffSum,
    output logic [pcoeffCountWidth-1:0] pcoeffCount
);

    logic [1:0] topChannelD;
    logic [1:0] topChannelDD;

    logic [botWidth-1:0] permutedBot;
    logic permutedBotValid;
    logic batchFinished;

    logic aggregateValid;
    logic [pcoeffSumWidth-1:0] aggregateSum;
    logic [pcoeffCountWidth-1:0] aggregateCount;

    pcoeffResult resultSlack;
    logic resultSlackValid;
    pcoeffResult headWord;
    logic fifoAlmostFull;
    logic fifoAlmostFullD;
    logic fifoEmpty;

    // Retiming stages only; topChannel is static while batches run
    always_ff @(posedge clk) begin
        if (rst) begin
            topChannelD <= '0;
            topChannelDD <= '0;
        end else begin
            topChannelD <= topChannel;
            topChannelDD <= topChannelD;
        end
    end

    botPermuter permuter (
        .clk(clk),
        .rst(rst),
        .bots(botsIn),
        .validBotsPermutes(validBotsPermutes),
        .batchesDone(batchesDone),
        .slowDownInputs(slowDownInputs),
        .requestSlowDown(fifoAlmostFullD),
        .permutedBot(permutedBot),
        .permutedBotValid(permutedBotValid),
        .batchFinished(batchFinished)
    );

    pcoeffAggregator aggregator (
        .clk(clk),
        .rst(rst),
        .topChannel(topChannelDD),
        .isBotValid(permutedBotValid),
        .bot(permutedBot),
        .lastBotOfBatch(batchFinished),
        .resultsValid(aggregateValid),
        .pcoeffSum(aggregateSum),
        .pcoeffCount(aggregateCount)
    );

    // Slack on the result and back-pressure paths
    always_ff @(posedge clk) begin
        resultSlack.fields.pcoeffSum <= aggregateSum;
        resultSlack.fields.pcoeffCount <= aggregateCount;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resultSlackValid <= 1'b0;
            fifoAlmostFullD <= 1'b0;
        end else begin
            resultSlackValid <= aggregateValid;
            fifoAlmostFullD <= fifoAlmostFull;
        end
    end

    resultsFifo results (
        .clk(clk),
        .rst(rst),
        .writeEnable(resultSlackValid),
        .dataIn(resultSlack.raw),
        .almostFull(fifoAlmostFull),
        .readEnable(grabResults),
        .dataOut(headWord.raw),
        .empty(fifoEmpty)
    );

    assign resultsAvailable = !fifoEmpty;
    assign pcoeffSum = headWord.fields.pcoeffSum;
    assign pcoeffCount = headWord.fields.pcoeffCount;

endmodule

`default_nettype wire

//--- src/botInputFifo.sv
`timescale 1ns/10ps
`default_nettype none

module botInputFifo import pipelineParams::*; (
    input  logic clk,
    input  logic rst,

    input  logic writeEnable,
    input  logic [botWidth-1:0] bot,
    input  logic [permuteWidth-1:0] permutes,
    input  logic lastOfBatch,
    output logic slowDown,

    input  logic readEnable,
    output logic [botWidth-1:0] headBot,
    output logic [permuteWidth-1:0] headPermutes,
    output logic headLast,
    output logic empty
);

    logic [botWidth-1:0] botMem [inputFifoDepth];
    logic [permuteWidth-1:0] permutesMem [inputFifoDepth];
    logic [inputFifoDepth-1:0] lastMem;

    logic [inputFifoDepthLog2-1:0] writePtr;
    logic [inputFifoDepthLog2-1:0] readPtr;
    logic [inputFifoDepthLog2:0] fillCount;
    logic doWrite;
    logic doRead;

    // Entries with an empty mask carry no work and are not stored
    assign doWrite = writeEnable && (|permutes) && (fillCount != inputFifoDepth);
    assign doRead = readEnable && !empty;

    assign empty = (fillCount == 0);
    assign headBot = botMem[readPtr];
    assign headPermutes = permutesMem[readPtr];
    assign headLast = lastMem[readPtr];

    always_ff @(posedge clk) begin
        if (doWrite) begin
            botMem[writePtr] <= bot;
            permutesMem[writePtr] <= permutes;
            lastMem[writePtr] <= lastOfBatch;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            writePtr <= '0;
            readPtr <= '0;
            fillCount <= '0;
            slowDown <= 1'b0;
        end else begin
            if (doWrite) begin
                writePtr <= writePtr + 1'b1;
            end
            if (doRead) begin
                readPtr <= readPtr + 1'b1;
            end
            case ({doWrite, doRead})
                2'b10: fillCount <= fillCount + 1'b1;
                2'b01: fillCount <= fillCount - 1'b1;
                default: fillCount <= fillCount;
            endcase
            // Producer gets two cycles of reaction time from the margin
            slowDown <= (inputFifoDepth - int'(fillCount)) <= inputFifoMargin;
        end
    end

endmodule

`default_nettype wire

//--- src/botPermuter.sv
`timescale 1ns/10ps
`default_nettype none

module botPermuter import pipelineParams::*; (
    input  logic clk,
    input  logic rst,

    input  logic [numberOfPermutators*botWidth-1:0] bots,
    input  logic [numberOfPermutators*permuteWidth-1:0] validBotsPermutes,
    input  logic [numberOfPermutators-1:0] batchesDone,
    output logic [numberOfPermutators-1:0] slowDownInputs,

    input  logic requestSlowDown,
    output logic [botWidth-1:0] permutedBot,
    output logic permutedBotValid,
    output logic batchFinished
);

    logic [botWidth-1:0] headBots [numberOfPermutators];
    logic [permuteWidth-1:0] headMasks [numberOfPermutators];
    logic [numberOfPermutators-1:0] headLasts;
    logic [numberOfPermutators-1:0] fifoEmpty;

    logic locked;
    logic [channelIndexWidth-1:0] owner;
    logic [channelIndexWidth-1:0] rrPointer;
    logic [channelIndexWidth-1:0] grantChannel;
    logic [channelIndexWidth-1:0] candidate;
    logic grantFound;

    logic maskLoaded;
    logic [permuteWidth-1:0] workMask;
    logic [permuteWidth-1:0] currentMask;
    logic [permuteWidth-1:0] remainingMask;
    logic [$clog2(permuteWidth)-1:0] swapIndex;
    logic lastCopy;
    logic emit;
    logic popHead;

    // Truth table of f with variable k and the top variable exchanged
    function automatic logic [botWidth-1:0] swapVariables(
        input logic [botWidth-1:0] truthTable,
        input logic [$clog2(permuteWidth)-1:0] k
    );
        logic [botWidth-1:0] result;
        logic [variableCount-1:0] idx;
        logic [variableCount-1:0] src;
        for (int i = 0; i < botWidth; i++) begin
            idx = variableCount'(i);
            src = idx;
            src[k] = idx[variableCount-1];
            src[variableCount-1] = idx[k];
            result[i] = truthTable[src];
        end
        return result;
    endfunction

    for (genvar c = 0; c < numberOfPermutators; c++) begin : gChannel
        botInputFifo inputFifo (
            .clk(clk),
            .rst(rst),
            .writeEnable(1'b1),
            .bot(bots[c*botWidth +: botWidth]),
            .permutes(validBotsPermutes[c*permuteWidth +: permuteWidth]),
            .lastOfBatch(batchesDone[c]),
            .slowDown(slowDownInputs[c]),
            .readEnable(popHead && (owner == channelIndexWidth'(c))),
            .headBot(headBots[c]),
            .headPermutes(headMasks[c]),
            .headLast(headLasts[c]),
            .empty(fifoEmpty[c])
        );
    end

    // Round robin starting after the last granted channel
    always_comb begin
        grantFound = 1'b0;
        grantChannel = rrPointer;
        candidate = rrPointer;
        for (int i = 1; i <= numberOfPermutators; i++) begin
            candidate = channelIndexWidth'((int'(rrPointer) + i) % numberOfPermutators);
            if (!grantFound && !fifoEmpty[candidate]) begin
                grantFound = 1'b1;
                grantChannel = candidate;
            end
        end
    end

    assign currentMask = maskLoaded ? workMask : headMasks[owner];
    assign remainingMask = currentMask & (currentMask - 1'b1);
    assign lastCopy = (remainingMask == '0);
    assign emit = locked && !fifoEmpty[owner] && !requestSlowDown;
    assign popHead = emit && lastCopy;

    // Lowest set bit goes first
    always_comb begin
        swapIndex = '0;
        for (int i = permuteWidth - 1; i >= 0; i--) begin
            if (currentMask[i]) begin
                swapIndex = ($clog2(permuteWidth))'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            permutedBot <= swapVariables(headBots[owner], swapIndex);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            locked <= 1'b0;
            owner <= '0;
            rrPointer <= '0;
            maskLoaded <= 1'b0;
            workMask <= '0;
            permutedBotValid <= 1'b0;
            batchFinished <= 1'b0;
        end else begin
            permutedBotValid <= emit;
            batchFinished <= popHead && headLasts[owner];
            if (!locked) begin
                if (grantFound) begin
                    locked <= 1'b1;
                    owner <= grantChannel;
                    rrPointer <= grantChannel;
                end
            end else if (emit) begin
                if (lastCopy) begin
                    maskLoaded <= 1'b0;
                    // Channel is held until its batch is through
                    if (headLasts[owner]) begin
                        locked <= 1'b0;
                    end
                end else begin
                    workMask <= remainingMask;
                    maskLoaded <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/pcoeffAggregator.sv
`timescale 1ns/10ps
`default_nettype none

module pcoeffAggregator import pipelineParams::*; (
    input  logic clk,
    input  logic rst,
    input  logic [1:0] topChannel,

    input  logic isBotValid,
    input  logic [botWidth-1:0] bot,
    input  logic lastBotOfBatch,

    output logic resultsValid,
    output logic [pcoeffSumWidth-1:0] pcoeffSum,
    output logic [pcoeffCountWidth-1:0] pcoeffCount
);

    logic [quarterWidth-1:0] quarter;
    logic [popcountWidth-1:0] quarterOnes;
    logic [pcoeffSumWidth-1:0] sumAcc;
    logic [pcoeffCountWidth-1:0] countAcc;
    logic [pcoeffSumWidth-1:0] nextSum;
    logic [pcoeffCountWidth-1:0] nextCount;

    assign quarter = bot[topChannel*quarterWidth +: quarterWidth];

    always_comb begin
        quarterOnes = '0;
        for (int i = 0; i < quarterWidth; i++) begin
            quarterOnes = quarterOnes + popcountWidth'(quarter[i]);
        end
    end

    assign nextSum = sumAcc + pcoeffSumWidth'(quarterOnes);
    assign nextCount = countAcc + 1'b1;

    // Totals include the closing bot
    always_ff @(posedge clk) begin
        if (isBotValid && lastBotOfBatch) begin
            pcoeffSum <= nextSum;
            pcoeffCount <= nextCount;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sumAcc <= '0;
            countAcc <= '0;
            resultsValid <= 1'b0;
        end else begin
            resultsValid <= isBotValid && lastBotOfBatch;
            if (isBotValid) begin
                if (lastBotOfBatch) begin
                    sumAcc <= '0;
                    countAcc <= '0;
                end else begin
                    sumAcc <= nextSum;
                    countAcc <= nextCount;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/pipelineParams.sv
`default_nettype none

package pipelineParams;

    localparam int numberOfPermutators = 2;
    localparam int channelIndexWidth = $clog2(numberOfPermutators);

    // A bot is the truth table of a 7-input function
    localparam int variableCount = 7;
    localparam int botWidth = 1 << variableCount;
    localparam int permuteWidth = variableCount - 1;
    localparam int quarterWidth = botWidth / 4;

    // A quarter holds at most 32 ones
    localparam int popcountWidth = $clog2(quarterWidth) + 1;
    localparam int pcoeffCountWidth = 16;
    localparam int pcoeffSumWidth = pcoeffCountWidth + popcountWidth;

    localparam int inputFifoDepthLog2 = 4;
    localparam int inputFifoDepth = 1 << inputFifoDepthLog2;
    localparam int inputFifoMargin = 4;
    localparam int resultsFifoDepthLog2 = 4;
    localparam int resultsFifoDepth = 1 << resultsFifoDepthLog2;
    localparam int resultsFifoMargin = 6;

endpackage

`default_nettype wire

//--- src/resultFormat.sv
`default_nettype none

package resultFormat;

    import pipelineParams::*;

    localparam int resultWidth = pcoeffSumWidth + pcoeffCountWidth;

    typedef struct packed {
        logic [pcoeffSumWidth-1:0] pcoeffSum;
        logic [pcoeffCountWidth-1:0] pcoeffCount;
    } pcoeffFields;

    // Same results word, seen flat by the FIFO and split at the outputs
    typedef union packed {
        logic [resultWidth-1:0] raw;
        pcoeffFields fields;
    } pcoeffResult;

endpackage

`default_nettype wire

//--- src/resultsFifo.sv
`timescale 1ns/10ps
`default_nettype none

module resultsFifo import pipelineParams::*, resultFormat::*; (
    input  logic clk,
    input  logic rst,

    input  logic writeEnable,
    input  logic [resultWidth-1:0] dataIn,
    output logic almostFull,

    input  logic readEnable,
    output logic [resultWidth-1:0] dataOut,
    output logic empty
);

    logic [resultWidth-1:0] mem [resultsFifoDepth];
    logic [resultsFifoDepthLog2-1:0] writePtr;
    logic [resultsFifoDepthLog2-1:0] readPtr;
    logic [resultsFifoDepthLog2:0] fillCount;
    logic doWrite;
    logic doRead;

    assign doWrite = writeEnable && (fillCount != resultsFifoDepth);
    assign doRead = readEnable && !empty;

    // Head word is always on the output
    assign dataOut = mem[readPtr];
    assign empty = (fillCount == 0);
    assign almostFull = int'(fillCount) >= resultsFifoDepth - resultsFifoMargin;

    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[writePtr] <= dataIn;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            writePtr <= '0;
            readPtr <= '0;
            fillCount <= '0;
        end else begin
            if (doWrite) begin
                writePtr <= writePtr + 1'b1;
            end
            if (doRead) begin
                readPtr <= readPtr + 1'b1;
            end
            case ({doWrite, doRead})
                2'b10: fillCount <= fillCount + 1'b1;
                2'b01: fillCount <= fillCount - 1'b1;
                default: fillCount <= fillCount;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- tests/aggregatingPermutePipelineTb.sv
`timescale 1ns/10ps
`default_nettype none

module aggregatingPermutePipelineTb import pipelineParams::*; ();

    localparam int wordWidth = pcoeffSumWidth + pcoeffCountWidth;

    logic clk = 1'b0;
    logic rst;
    logic [1:0] topChannel;
    logic [numberOfPermutators*botWidth-1:0] botsIn;
    logic [numberOfPermutators*permuteWidth-1:0] validBotsPermutes;
    logic [numberOfPermutators-1:0] batchesDone;
    logic [numberOfPermutators-1:0] slowDownInputs;
    logic grabResults;
    logic resultsAvailable;
    logic [pcoeffSumWidth-1:0] pcoeffSum;
    logic [pcoeffCountWidth-1:0] pcoeffCount;

    logic [botWidth-1:0] chBot [numberOfPermutators];
    logic [permuteWidth-1:0] chMask [numberOfPermutators];
    logic chLast [numberOfPermutators];

    logic [wordWidth-1:0] expected0 [$];
    logic [wordWidth-1:0] expected1 [$];
    logic popEnable;
    logic writesStarted;
    logic sawSlowDown;
    logic matched;
    logic [wordWidth-1:0] popped;
    logic [wordWidth-1:0] headWord;
    int errorCount;
    int popCount;
    int batchesSent;
    int cycleCount;
    int cycleLimit;
    int holdCycles;

    aggregatingPermutePipeline dut_i (
        .clk(clk),
        .rst(rst),
        .topChannel(topChannel),
        .botsIn(botsIn),
        .validBotsPermutes(validBotsPermutes),
        .batchesDone(batchesDone),
        .slowDownInputs(slowDownInputs),
        .grabResults(grabResults),
        .resultsAvailable(resultsAvailable),
        .pcoeffSum(pcoeffSum),
        .pcoeffCount(pcoeffCount)
    );

    always #20 clk = ~clk;

    always_comb begin
        for (int c = 0; c < numberOfPermutators; c++) begin
            botsIn[c*botWidth +: botWidth] = chBot[c];
            validBotsPermutes[c*permuteWidth +: permuteWidth] = chMask[c];
            batchesDone[c] = chLast[c];
        end
    end

    // Bit i of the result reads the input with variables k and 6 exchanged
    function automatic logic [botWidth-1:0] swapModel(input logic [botWidth-1:0] value,
                                                      input int k);
        logic [botWidth-1:0] swapped;
        int j;
        for (int i = 0; i < botWidth; i++) begin
            j = i;
            if (((i >> k) & 1) != ((i >> 6) & 1)) begin
                j = i ^ ((1 << k) | (1 << 6));
            end
            swapped[i] = value[j];
        end
        return swapped;
    endfunction

    function automatic int quarterOnes(input logic [botWidth-1:0] value, input int q);
        int ones;
        ones = 0;
        for (int i = 0; i < botWidth / 4; i++) begin
            ones += int'(value[q*(botWidth/4) + i]);
        end
        return ones;
    endfunction

    task automatic sendBatch(input int ch, input int botCount, input bit oneHot);
        logic [botWidth-1:0] bot;
        logic [permuteWidth-1:0] mask;
        logic [pcoeffSumWidth-1:0] sum;
        logic [pcoeffCountWidth-1:0] count;
        int b;
        sum = '0;
        count = '0;
        b = 0;
        cycleLimit += 200 + 6 * botCount;
        while (b < botCount) begin
            @(posedge clk);
            if (slowDownInputs[ch]) begin
                chMask[ch] <= '0;
            end else begin
                bot = {$urandom(), $urandom(), $urandom(), $urandom()};
                if (oneHot) begin
                    mask = permuteWidth'(1 << (b % permuteWidth));
                end else begin
                    mask = permuteWidth'($urandom_range(63, 1));
                end
                for (int k = 0; k < permuteWidth; k++) begin
                    if (mask[k]) begin
                        sum = sum + pcoeffSumWidth'(quarterOnes(swapModel(bot, k), topChannel));
                        count = count + 1'b1;
                    end
                end
                chBot[ch] <= bot;
                chMask[ch] <= mask;
                chLast[ch] <= (b == botCount - 1);
                writesStarted = 1'b1;
                b++;
            end
        end
        @(posedge clk);
        chMask[ch] <= '0;
        chLast[ch] <= 1'b0;
        if (ch == 0) begin
            expected0.push_back({sum, count});
        end else begin
            expected1.push_back({sum, count});
        end
        batchesSent++;
    endtask

    task automatic runBatches(input int ch, input int batches, input int maxBots);
        for (int n = 0; n < batches; n++) begin
            sendBatch(ch, $urandom_range(maxBots, 1), 1'b0);
        end
    endtask

    task automatic waitForDrain();
        while (expected0.size() != 0 || expected1.size() != 0) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);
    endtask

    // Nothing may come out before the first bot goes in
    idleAfterReset: assert property (@(posedge clk) disable iff (rst)
        !writesStarted |-> (slowDownInputs == '0 && !resultsAvailable))
    else begin
        errorCount++;
        $display("Outputs active at %0t before any bot was written", $time);
    end

    // A pop happens on an edge where grabResults and resultsAvailable are both high
    always @(posedge clk) begin
        if (!rst && grabResults && resultsAvailable) begin
            popped = {pcoeffSum, pcoeffCount};
            popCount++;
            matched = 1'b0;
            if (expected0.size() > 0 && expected0[0] == popped) begin
                void'(expected0.pop_front());
                matched = 1'b1;
            end else if (expected1.size() > 0 && expected1[0] == popped) begin
                void'(expected1.pop_front());
                matched = 1'b1;
            end
            popMatchesModel: assert (matched) else begin
                errorCount++;
                if (expected0.size() == 0 && expected1.size() == 0) begin
                    $display("Result popped at %0t while no batch was outstanding", $time);
                end else begin
                    headWord = (expected0.size() > 0) ? expected0[0] : expected1[0];
                    if (pcoeffSum != headWord[wordWidth-1:pcoeffCountWidth]) begin
                        $display("[FAIL] %0t pcoeffSum got %0d expected %0d",
                                 $time, pcoeffSum, headWord[wordWidth-1:pcoeffCountWidth]);
                    end
                    if (pcoeffCount != headWord[pcoeffCountWidth-1:0]) begin
                        $display("[FAIL] %0t pcoeffCount got %0d expected %0d",
                                 $time, pcoeffCount, headWord[pcoeffCountWidth-1:0]);
                    end
                end
            end
        end
        grabResults <= popEnable;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout after %0d cycles with %0d results still outstanding",
                     cycleCount, expected0.size() + expected1.size());
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'hfcd6_ac86));
        rst = 1'b1;
        topChannel = 2'd0;
        grabResults = 1'b0;
        popEnable = 1'b1;
        writesStarted = 1'b0;
        sawSlowDown = 1'b0;
        errorCount = 0;
        popCount = 0;
        batchesSent = 0;
        cycleCount = 0;
        cycleLimit = 2000;
        holdCycles = 0;
        for (int c = 0; c < numberOfPermutators; c++) begin
            chBot[c] = '0;
            chMask[c] = '0;
            chLast[c] = 1'b0;
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        repeat (10) @(posedge clk);

        // One copy per bot as k walks 0 to 5
        sendBatch(0, 6, 1'b1);
        waitForDrain();

        // Both channels at once
        topChannel <= 2'd2;
        repeat (4) @(posedge clk);
        fork
            runBatches(0, 6, 8);
            runBatches(1, 6, 8);
        join
        waitForDrain();

        // Results held back until the inputs push back
        popEnable <= 1'b0;
        fork
            runBatches(0, 14, 2);
            runBatches(1, 14, 2);
            begin
                holdCycles = 0;
                while (slowDownInputs == '0 && holdCycles < 400) begin
                    @(posedge clk);
                    holdCycles++;
                end
                sawSlowDown = (slowDownInputs != '0);
                repeat (40) @(posedge clk);
                popEnable <= 1'b1;
            end
        join
        waitForDrain();
        slowDownSeen: assert (sawSlowDown) else begin
            errorCount++;
            $display("slowDownInputs never rose while results were held back");
        end

        for (int q = 0; q < 4; q++) begin
            topChannel <= 2'(q);
            repeat (4) @(posedge clk);
            sendBatch(q % 2, $urandom_range(5, 1), 1'b0);
            waitForDrain();
        end

        popsMatchBatches: assert (popCount == batchesSent) else begin
            errorCount++;
            $display("%0d results popped for %0d batches", popCount, batchesSent);
        end

        $display("Checks done: %0d errors, %0d results popped, %0d batches sent",
                 errorCount, popCount, batchesSent);
        if (errorCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
